/* include/pwm_macros.svh */
/*
 * bus geometry and PWM channel map
 * address and data widths, channel base addresses, registers per channel
 */

`ifndef PWM_MACROS_SVH
`define PWM_MACROS_SVH

`define BUS_ADDR_W    16
`define BUS_DATA_W    8

// channel base addresses, three bytes apart
`define PWM0_BASE     16'hFF1A
`define PWM1_BASE     16'hFF1D

`define PWM_REG_COUNT 3 // period, duty, ctrl

`endif

/* source/periph_bus_pkg.sv */
/*
 * peripheral bus types
 * address and data bytes, and the request bundle that is sent
 * to every peripheral on the bus
 */

`include "pwm_macros.svh"

package periph_bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;

    // plain level signals, no handshake
    // a write lands on the edge where enable and write_en are both high
    typedef struct packed {
        logic      enable;
        logic      write_en;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

endpackage

/* source/pwm_pkg.sv */
/*
 * PWM channel types
 * period and duty values, the control byte, register offsets
 */

package pwm_pkg;

    // period and duty are both plain bytes
    typedef logic [7:0] pwm_val_t;

    // control register
    // invert sits in bit 0, the rest is kept but has no effect
    typedef struct packed {
        logic [6:0] reserved; // read back as written
        logic       invert;   // flips the output pin
    } pwm_ctrl_t;

    // offset of a register from the channel base
    typedef enum logic [1:0] {
        REG_PERIOD = 2'd0,
        REG_DUTY   = 2'd1,
        REG_CTRL   = 2'd2
    } pwm_reg_e;

endpackage

/* source/rw_register.sv */
/*
 * rw_register
 * one bus register of any byte-sized type, written on a selected
 * write and read back while selected
 */

module rw_register
    import periph_bus_pkg::*;
#(
    parameter type data_t = bus_data_t,
    parameter data_t reset_value = '0
)(
    input  logic      clk,
    input  logic      reset,
    input  logic      sel,      // already qualified with bus enable
    input  logic      write_en,
    input  bus_data_t wdata,
    output data_t     value,
    output bus_data_t rdata
);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            value <= reset_value;
        end
        else if (sel && write_en)
        begin
            value <= data_t'(wdata);
        end
    end

    // zero when not addressed so the peripheral can OR its registers together
    assign rdata = sel ? bus_data_t'(value) : '0;

    // contents only move on a selected write
    a_value_hold : assert property (
        @(posedge clk) disable iff (!reset)
        !(sel && write_en) |=> $stable(value)
    ) else $error("rw_register value changed without a write");

endmodule

/* source/tick_counter.sv */
/*
 * tick_counter
 * free-running cycle counter that wraps at a programmable limit,
 * with a synchronous restart
 */

module tick_counter #(
    parameter int width = 8
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             restart,
    input  logic [width-1:0] limit,   // period length in cycles
    output logic [width-1:0] count
);

    logic [width:0] count_inc; // one bit wider so 8'hFF + 1 does not wrap
    logic           last_tick;

    assign count_inc = {1'b0, count} + 1'b1;

    // also true when limit dropped below count, or limit is 0 or 1
    assign last_tick = (count_inc >= {1'b0, limit});

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (restart || last_tick)
        begin
            count <= '0;
        end
        else
        begin
            count <= count_inc[width-1:0];
        end
    end

    // a limit that changed last cycle may still see the old count once
    a_count_range : assert property (
        @(posedge clk) disable iff (!reset)
        ($stable(limit) && (limit > 1)) |-> (count < limit)
    ) else $error("tick_counter count %0d not below limit %0d", count, limit);

endmodule

/* source/pwm_core.sv */
/*
 * pwm_core
 * turns a period and a duty value into a registered waveform,
 * restarting the period whenever either value changes
 */

module pwm_core
    import pwm_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pwm_val_t period,
    input  pwm_val_t duty,
    output logic     wave
);

    pwm_val_t prev_period;
    pwm_val_t prev_duty;
    pwm_val_t count;
    logic     restart;
    logic     wave_next;

    // remember last settings to spot a change
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            prev_period <= '0;
            prev_duty   <= '0;
        end
        else
        begin
            prev_period <= period;
            prev_duty   <= duty;
        end
    end

    // high for exactly one cycle after a new value shows up
    assign restart = (period != prev_period) || (duty != prev_duty);

    tick_counter #(
        .width ($bits(pwm_val_t))
    ) u_tick_counter (
        .clk     (clk),
        .reset   (reset),
        .restart (restart),
        .limit   (period),
        .count   (count)
    );

    // duty 0 is always off, duty at or above period always on
    always_comb
    begin
        if (duty == '0)
        begin
            wave_next = 1'b0;
        end
        else if (duty >= period)
        begin
            wave_next = 1'b1;
        end
        else
        begin
            wave_next = (count < duty); // first duty cycles of each period
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wave <= 1'b0;
        end
        else
        begin
            wave <= wave_next;
        end
    end

    // a settled zero duty keeps the output low
    a_zero_duty_low : assert property (
        @(posedge clk) disable iff (!reset)
        ((duty == '0) && ($past(duty) == '0)) |=> !wave
    ) else $error("pwm_core wave high with zero duty");

endmodule

/* source/pwm_peripheral.sv */
/*
 * pwm_peripheral
 * one PWM channel on the bus: address decode, period, duty and
 * control registers, the waveform core and output polarity
 */

`include "pwm_macros.svh"

module pwm_peripheral
    import periph_bus_pkg::*, pwm_pkg::*;
#(
    parameter bus_addr_t base_addr = `PWM0_BASE
)(
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  req,
    output bus_data_t rdata,
    output logic      pwm_out
);

    bus_addr_t                   offset;
    logic                        hit;
    pwm_reg_e                    reg_sel;
    logic [`PWM_REG_COUNT-1:0]   sel;      // one bit per register, by offset
    bus_data_t                   period_rdata;
    bus_data_t                   duty_rdata;
    bus_data_t                   ctrl_rdata;
    pwm_val_t                    period;
    pwm_val_t                    duty;
    pwm_ctrl_t                   ctrl;
    logic                        wave;

    assign offset  = req.addr - base_addr;
    assign hit     = req.enable && (req.addr >= base_addr) && (offset < `PWM_REG_COUNT);
    assign reg_sel = pwm_reg_e'(offset[1:0]);

    assign sel[REG_PERIOD] = hit && (reg_sel == REG_PERIOD);
    assign sel[REG_DUTY]   = hit && (reg_sel == REG_DUTY);
    assign sel[REG_CTRL]   = hit && (reg_sel == REG_CTRL);

    rw_register #(.data_t(pwm_val_t), .reset_value('0)) u_period_reg (
        .clk      (clk),
        .reset    (reset),
        .sel      (sel[REG_PERIOD]),
        .write_en (req.write_en),
        .wdata    (req.wdata),
        .value    (period),
        .rdata    (period_rdata)
    );

    rw_register #(.data_t(pwm_val_t), .reset_value('0)) u_duty_reg (
        .clk      (clk),
        .reset    (reset),
        .sel      (sel[REG_DUTY]),
        .write_en (req.write_en),
        .wdata    (req.wdata),
        .value    (duty),
        .rdata    (duty_rdata)
    );

    rw_register #(.data_t(pwm_ctrl_t), .reset_value('0)) u_ctrl_reg (
        .clk      (clk),
        .reset    (reset),
        .sel      (sel[REG_CTRL]),
        .write_en (req.write_en),
        .wdata    (req.wdata),
        .value    (ctrl),
        .rdata    (ctrl_rdata)
    );

    // unselected registers return zero
    assign rdata = period_rdata | duty_rdata | ctrl_rdata;

    pwm_core u_pwm_core (
        .clk    (clk),
        .reset  (reset),
        .period (period),
        .duty   (duty),
        .wave   (wave)
    );

    assign pwm_out = wave ^ ctrl.invert; // polarity applied after the core

    a_sel_onehot : assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0(sel)
    ) else $error("pwm_peripheral selects more than one register");

endmodule

/* source/pwm_subsystem.sv */
/*
 * pwm_subsystem
 * top level with two PWM channels sharing one bus request,
 * read data ORed together
 */

`include "pwm_macros.svh"

module pwm_subsystem
    import periph_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   req,
    output bus_data_t  rdata,
    output logic [1:0] pwm_out
);

    bus_data_t pwm0_rdata;
    bus_data_t pwm1_rdata;

    // channel 0
    pwm_peripheral #(
        .base_addr (`PWM0_BASE)
    ) u_pwm0 (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .rdata   (pwm0_rdata),
        .pwm_out (pwm_out[0])
    );

    // channel 1, right after channel 0
    pwm_peripheral #(
        .base_addr (`PWM1_BASE)
    ) u_pwm1 (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .rdata   (pwm1_rdata),
        .pwm_out (pwm_out[1])
    );

    // each channel drives zero outside its own range
    assign rdata = pwm0_rdata | pwm1_rdata;

endmodule

/* tb/tb_pwm_subsystem.sv */
/*
 * directed testbench for the two-channel PWM subsystem
 * clock and reset, bus read and write tasks, value check,
 * pin high-time measurement and the test sequence
 */

`include "pwm_macros.svh"

module tb_pwm_subsystem
    import periph_bus_pkg::*, pwm_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int       clk_period = 40;
    localparam int       wait_limit = 2000; // longest wait allowed, in cycles
    localparam bus_req_t idle_req   = '0;

    logic       clk;
    logic       reset;
    bus_req_t   req;
    bus_data_t  rdata;
    logic [1:0] pwm_out;

    pwm_subsystem u_dut (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .rdata   (rdata),
        .pwm_out (pwm_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string test_name, input int expected, input int actual);
        if (expected != actual)
        begin
            abort_run($sformatf("Fail %s expected %0d actual %0d", test_name, expected, actual));
        end
    endtask

    task automatic wait_cycles(input int cycles);
        int waited;
        waited = 0;
        while (waited < cycles)
        begin
            @(posedge clk);
            waited++;
            if (waited >= wait_limit)
            begin
                abort_run($sformatf("timeout: wait of %0d cycles ran too long", cycles));
            end
        end
    endtask

    function automatic bus_addr_t chan_addr(input logic ch, input pwm_reg_e off);
        bus_addr_t base;
        base = ch ? bus_addr_t'(`PWM1_BASE) : bus_addr_t'(`PWM0_BASE);
        return base + bus_addr_t'(off);
    endfunction

    // high cycles expected in a 4-period window
    function automatic int expected_high(input int period, input int duty, input bit invert);
        int highs;
        if (duty == 0)
            highs = 0;
        else if (duty >= period)
            highs = 4 * period;
        else
            highs = 4 * duty;
        if (invert)
            highs = 4 * period - highs; // polarity flips every cycle of the window
        return highs;
    endfunction

    task automatic bus_write(input bus_addr_t address, input bus_data_t data);
        @(posedge clk);
        req <= '{enable: 1'b1, write_en: 1'b1, addr: address, wdata: data};
        @(posedge clk);
        req <= idle_req; // write lands on this edge
    endtask

    // drive any request for one cycle, read data taken mid-cycle
    task automatic bus_sample(input bus_req_t r, output bus_data_t data);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        data = rdata;
        @(posedge clk);
        req <= idle_req;
    endtask

    task automatic bus_read(input bus_addr_t address, output bus_data_t data);
        bus_sample('{enable: 1'b1, write_en: 1'b0, addr: address, wdata: '0}, data);
    endtask

    task automatic measure_high(input logic ch, input int cycles, output int highs);
        highs = 0;
        if (cycles >= wait_limit)
        begin
            abort_run($sformatf("timeout: window of %0d cycles is too long", cycles));
        end
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (pwm_out[ch])
                highs++;
        end
    endtask

    task automatic configure(input logic ch, input int period, input int duty);
        bus_write(chan_addr(ch, REG_PERIOD), bus_data_t'(period));
        bus_write(chan_addr(ch, REG_DUTY), bus_data_t'(duty));
    endtask

    task automatic set_invert(input logic ch, input logic invert);
        pwm_ctrl_t ctrl;
        ctrl = '{reserved: '0, invert: invert};
        bus_write(chan_addr(ch, REG_CTRL), bus_data_t'(ctrl));
    endtask

    // let the restart settle, then count over four whole periods
    task automatic check_pin(input string test_name, input logic ch, input int period,
                             input int duty, input bit invert);
        int highs;
        wait_cycles(2 * period);
        measure_high(ch, 4 * period, highs);
        check(test_name, expected_high(period, duty, invert), highs);
    endtask

    task automatic test_reset_state();
        bus_data_t data;
        int        highs;
        for (int c = 0; c < 2; c++)
        begin
            for (int r = 0; r < `PWM_REG_COUNT; r++)
            begin
                bus_read(chan_addr(1'(c), pwm_reg_e'(r)), data);
                check($sformatf("reset ch%0d reg%0d", c, r), 0, int'(data));
            end
            measure_high(1'(c), 100, highs);
            check($sformatf("reset ch%0d pin", c), 0, highs);
        end
    endtask

    task automatic test_register_readback();
        bus_data_t data;
        bus_data_t value;
        bus_data_t written[$];
        for (int c = 0; c < 2; c++)
        begin
            for (int r = 0; r < `PWM_REG_COUNT; r++)
            begin
                value = bus_data_t'($urandom);
                written.push_back(value);
                bus_write(chan_addr(1'(c), pwm_reg_e'(r)), value);
            end
        end
        for (int c = 0; c < 2; c++)
        begin
            for (int r = 0; r < `PWM_REG_COUNT; r++)
            begin
                bus_read(chan_addr(1'(c), pwm_reg_e'(r)), data);
                value = written.pop_front();
                check($sformatf("readback ch%0d reg%0d", c, r), int'(value), int'(data));
            end
        end
        // neighbours just outside both channels
        bus_read(bus_addr_t'(`PWM0_BASE - 16'd1), data);
        check("unmapped below ch0", 0, int'(data));
        bus_read(bus_addr_t'(`PWM1_BASE + 16'd3), data);
        check("unmapped above ch1", 0, int'(data));
        // enable low must neither answer nor write
        value = bus_data_t'($urandom);
        bus_write(chan_addr(1'b0, REG_DUTY), value);
        bus_sample('{enable: 1'b0, write_en: 1'b1, addr: chan_addr(1'b0, REG_DUTY),
                     wdata: ~value}, data);
        check("enable low rdata", 0, int'(data));
        bus_read(chan_addr(1'b0, REG_DUTY), data);
        check("enable low no write", int'(value), int'(data));
    endtask

    task automatic test_random_duty();
        int p0;
        int d0;
        int p1;
        int d1;
        set_invert(1'b0, 1'b0);
        set_invert(1'b1, 1'b0);
        for (int round = 0; round < 4; round++)
        begin
            p0 = 2 + int'($urandom % 19);
            d0 = 1 + int'($urandom % (p0 - 1));
            p1 = 2 + int'($urandom % 19);
            d1 = 1 + int'($urandom % (p1 - 1));
            configure(1'b0, p0, d0);
            configure(1'b1, p1, d1);
            check_pin($sformatf("random r%0d ch0 P%0d D%0d", round, p0, d0), 1'b0, p0, d0, 0);
            check_pin($sformatf("random r%0d ch1 P%0d D%0d", round, p1, d1), 1'b1, p1, d1, 0);
        end
    endtask

    task automatic test_duty_limits();
        configure(1'b0, 12, 0);
        check_pin("duty zero", 1'b0, 12, 0, 0);
        configure(1'b0, 12, 12);
        check_pin("duty equal period", 1'b0, 12, 12, 0);
        configure(1'b0, 12, 20);
        check_pin("duty above period", 1'b0, 12, 20, 0);
    endtask

    task automatic test_invert();
        configure(1'b0, 10, 3);
        configure(1'b1, 16, 5);
        set_invert(1'b1, 1'b1);
        check_pin("invert ch1", 1'b1, 16, 5, 1);
        check_pin("invert ch0 untouched", 1'b0, 10, 3, 0);
        set_invert(1'b1, 1'b0);
        check_pin("invert cleared ch1", 1'b1, 16, 5, 0);
    endtask

    task automatic test_duty_change();
        configure(1'b0, 10, 3);
        check_pin("duty before change", 1'b0, 10, 3, 0);
        wait_cycles(1 + int'($urandom % 9)); // land somewhere inside a period
        bus_write(chan_addr(1'b0, REG_DUTY), 8'd7);
        check_pin("duty after change", 1'b0, 10, 7, 0);
    endtask

    initial
    begin
        void'($urandom(78));
        reset = 1'b0;
        req   = idle_req;
        wait_cycles(5);
        reset <= 1'b1;
        test_reset_state();
        test_register_readback();
        test_random_duty();
        test_duty_limits();
        test_invert();
        test_duty_change();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
source/periph_bus_pkg.sv
source/pwm_pkg.sv
source/rw_register.sv
source/tick_counter.sv
source/pwm_core.sv
source/pwm_peripheral.sv
source/pwm_subsystem.sv
tb/tb_pwm_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sim.f --top-module tb_pwm_subsystem \
    && ./obj_dir/Vtb_pwm_subsystem | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "pwm run ok" \
    || { echo "pwm run not ok"; exit 1; }
